// ==== include/core_consts.svh ====
// ####################
// Core sizing constants
// ####################

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Instruction queue depth
`define IQ_ENTRIES 4

// Datapath width in bits
`define XLEN 32

// Architectural integer registers
`define NUM_REGS 32

`endif

// ==== hdl/core_pkg.sv ====
// ####################
// Core types shared by the decode, execute and queue blocks
// ####################

package core_pkg;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // I-type field layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // One instruction word, seen either way
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_NONE
    } alu_op_e;

    // Queue entry with arrival tag
    typedef struct packed {
        instr_u     word;
        logic [7:0] tag;
    } iq_entry_t;

endpackage

// ==== hdl/stage_if.sv ====
// ####################
// Stage links from decode to execute and execute to writeback
// ####################

`include "core_consts.svh"

interface issue_if
    import core_pkg::*;
();
    logic              valid;
    alu_op_e           op;
    logic [`XLEN-1:0]  operand_a;
    logic [`XLEN-1:0]  operand_b;
    logic [4:0]        rd;
    logic              illegal;
    logic [7:0]        tag;
    logic              stall;
    // Destination still pending in execute
    logic [4:0]        ex_busy_rd;

    modport decode (output valid, op, operand_a, operand_b, rd, illegal, tag,
                    input stall, ex_busy_rd);
    modport execute (input valid, op, operand_a, operand_b, rd, illegal, tag,
                     output stall, ex_busy_rd);
endinterface

interface exec_if;
    logic             valid;
    logic [4:0]       rd;
    logic [`XLEN-1:0] value;
    logic             illegal;
    logic [7:0]       tag;
    logic             stall;

    modport execute (output valid, rd, value, illegal, tag, input stall);
    modport writeback (input valid, rd, value, illegal, tag, output stall);
endinterface

// ==== hdl/instr_queue.sv ====
// ####################
// Circular instruction buffer, registered head output
// ####################

`include "core_consts.svh"

module instr_queue
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      write,
    input  logic      read,
    input  iq_entry_t data_in,
    output iq_entry_t data_out,
    output logic      valid_out,
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = $clog2(`IQ_ENTRIES);
    localparam int CNT_W = PTR_W + 1;

    iq_entry_t        mem [`IQ_ENTRIES];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             load_out;
    logic             from_mem;
    logic             bypass;
    logic             store;

    // Count covers the array only, the head word sits in data_out
    assign empty = !valid_out;
    assign full  = (count == CNT_W'(`IQ_ENTRIES));

    // Output register refills when idle or when its word is taken
    assign load_out = empty || read;
    assign from_mem = load_out && (count != '0);
    assign bypass   = load_out && (count == '0) && write;
    assign store    = write && !bypass;

    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            valid_out <= 1'b0;
        end else begin
            if (store) begin
                tail <= (tail == PTR_W'(`IQ_ENTRIES - 1)) ? '0 : tail + 1'b1;
            end
            if (from_mem) begin
                head <= (head == PTR_W'(`IQ_ENTRIES - 1)) ? '0 : head + 1'b1;
            end
            if (load_out) begin
                valid_out <= from_mem || bypass;
            end
            count <= count + CNT_W'(store) - CNT_W'(from_mem);
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            mem[tail] <= data_in;
        end
        if (from_mem) begin
            data_out <= mem[head];
        end else if (bypass) begin
            data_out <= data_in;
        end
    end

    // Producer must respect full
    a_no_write_full : assert property (@(posedge clk) disable iff (reset)
        full |-> !write);

endmodule

// ==== hdl/decode_unit.sv ====
// ####################
// Decode, register read and RAW hazard stall
// ####################

`include "core_consts.svh"

module decode_unit
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  iq_entry_t        q_entry,
    input  logic             q_valid,
    output logic             q_read,
    output logic [4:0]       rf_raddr_a,
    output logic [4:0]       rf_raddr_b,
    input  logic [`XLEN-1:0] rf_rdata_a,
    input  logic [`XLEN-1:0] rf_rdata_b,
    input  logic [4:0]       wb_busy_rd,
    issue_if.decode          issue
);

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    instr_u           word;
    logic             is_r;
    logic             is_i;
    logic             legal_r;
    logic             legal_i;
    alu_op_e          op;
    logic             illegal;
    logic [`XLEN-1:0] imm;
    logic [4:0]       own_busy_rd;
    logic             hazard;
    logic             load;

    function automatic logic reg_busy(input logic [4:0] rs, input logic [4:0] a,
                                      input logic [4:0] b, input logic [4:0] c);
        return (rs != 5'd0) && (rs == a || rs == b || rs == c);
    endfunction

    assign word = q_entry.word;
    assign is_r = (word.r_fields.opcode == OPC_REG);
    assign is_i = (word.i_fields.opcode == OPC_IMM);

    always_comb begin
        op = OP_NONE;
        if (is_r) begin
            case ({word.r_fields.funct7, word.r_fields.funct3})
                {7'b0000000, 3'b000}: op = OP_ADD;
                {7'b0100000, 3'b000}: op = OP_SUB;
                {7'b0000000, 3'b111}: op = OP_AND;
                {7'b0000000, 3'b110}: op = OP_OR;
                {7'b0000000, 3'b100}: op = OP_XOR;
                {7'b0000000, 3'b010}: op = OP_SLT;
                default:              op = OP_NONE;
            endcase
        end else if (is_i) begin
            case (word.i_fields.funct3)
                3'b000:  op = OP_ADD;
                3'b111:  op = OP_AND;
                3'b110:  op = OP_OR;
                3'b100:  op = OP_XOR;
                3'b010:  op = OP_SLT;
                default: op = OP_NONE;
            endcase
        end
    end

    // Legal encodings, checked apart from the op table
    assign legal_r = is_r &&
        ((word.r_fields.funct7 == 7'b0000000 &&
          word.r_fields.funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) ||
         (word.r_fields.funct7 == 7'b0100000 && word.r_fields.funct3 == 3'b000));
    assign legal_i = is_i &&
        (word.i_fields.funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111});

    assign illegal    = !(legal_r || legal_i);
    assign imm        = {{(`XLEN - 12){word.i_fields.imm12[11]}}, word.i_fields.imm12};
    assign rf_raddr_a = word.r_fields.rs1;
    assign rf_raddr_b = word.r_fields.rs2;

    // The word held in our own output register is also in flight
    assign own_busy_rd = issue.valid ? issue.rd : 5'd0;
    assign hazard = !illegal &&
        (reg_busy(rf_raddr_a, wb_busy_rd, issue.ex_busy_rd, own_busy_rd) ||
         (is_r && reg_busy(rf_raddr_b, wb_busy_rd, issue.ex_busy_rd, own_busy_rd)));

    assign load   = q_valid && !hazard && (!issue.valid || !issue.stall);
    assign q_read = load;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (!issue.valid || !issue.stall) begin
            issue.valid <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            issue.op        <= op;
            issue.operand_a <= illegal ? '0 : rf_rdata_a;
            issue.operand_b <= illegal ? '0 : (is_r ? rf_rdata_b : imm);
            issue.rd        <= illegal ? 5'd0 : word.r_fields.rd;
            issue.illegal   <= illegal;
            issue.tag       <= q_entry.tag;
        end
    end

    // Every legal issue carries a real operation
    a_legal_has_op : assert property (@(posedge clk) disable iff (reset)
        issue.valid && !issue.illegal |-> issue.op != OP_NONE);

endmodule

// ==== hdl/alu_execute.sv ====
// ####################
// Single-stage ALU holding one result
// ####################

`include "core_consts.svh"

module alu_execute
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    issue_if.execute  issue,
    exec_if.execute   result
);

    logic [`XLEN-1:0] alu_value;
    logic             take;

    // Blocked only while our result waits on writeback
    assign issue.stall = result.valid && result.stall;
    assign take        = !issue.stall;

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_value = issue.operand_a + issue.operand_b;
            OP_SUB:  alu_value = issue.operand_a - issue.operand_b;
            OP_AND:  alu_value = issue.operand_a & issue.operand_b;
            OP_OR:   alu_value = issue.operand_a | issue.operand_b;
            OP_XOR:  alu_value = issue.operand_a ^ issue.operand_b;
            OP_SLT: begin
                alu_value = {{(`XLEN - 1){1'b0}},
                             $signed(issue.operand_a) < $signed(issue.operand_b)};
            end
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (take) begin
            result.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take && issue.valid) begin
            result.rd      <= issue.rd;
            result.value   <= issue.illegal ? '0 : alu_value;
            result.illegal <= issue.illegal;
            result.tag     <= issue.tag;
        end
    end

    // Destination not yet visible in the register file
    assign issue.ex_busy_rd = result.valid ? result.rd : 5'd0;

endmodule

// ==== hdl/result_writeback.sv ====
// ####################
// Register file and four-phase result port
// ####################

`include "core_consts.svh"

module result_writeback (
    input  logic             clk,
    input  logic             reset,
    exec_if.writeback        result,
    input  logic [4:0]       rf_raddr_a,
    input  logic [4:0]       rf_raddr_b,
    output logic [`XLEN-1:0] rf_rdata_a,
    output logic [`XLEN-1:0] rf_rdata_b,
    output logic [4:0]       wb_busy_rd,
    output logic             result_req,
    input  logic             result_ack,
    output logic [4:0]       result_rd,
    output logic [`XLEN-1:0] result_value,
    output logic             result_illegal,
    output logic [7:0]       result_tag
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             accept;
    logic             retire;

    // No new result while a req is up or the last ack is still high
    assign result.stall = result_req || result_ack;
    assign accept       = result.valid && !result.stall;
    assign retire       = result_req && result_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_req <= 1'b0;
        end else if (accept) begin
            result_req <= 1'b1;
        end else if (retire) begin
            result_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result_rd      <= result.rd;
            result_value   <= result.value;
            result_illegal <= result.illegal;
            result_tag     <= result.tag;
        end
    end

    // Architectural state starts at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire && !result_illegal && result_rd != 5'd0) begin
            regs[result_rd] <= result_value;
        end
    end

    // x0 reads as zero
    assign rf_rdata_a = (rf_raddr_a == 5'd0) ? '0 : regs[rf_raddr_a];
    assign rf_rdata_b = (rf_raddr_b == 5'd0) ? '0 : regs[rf_raddr_b];

    assign wb_busy_rd = result_req ? result_rd : 5'd0;

    // Offered data holds until the consumer acks
    a_result_stable : assert property (@(posedge clk) disable iff (reset)
        result_req && !result_ack |=> result_req &&
        $stable({result_rd, result_value, result_illegal, result_tag}));

endmodule

// ==== hdl/mini_core_top.sv ====
// ####################
// Core slice top with four-phase instruction and result ports
// ####################

`include "core_consts.svh"

module mini_core_top
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_req,
    input  logic [`XLEN-1:0] instr_word,
    output logic             instr_ack,
    output logic             result_req,
    input  logic             result_ack,
    output logic [4:0]       result_rd,
    output logic [`XLEN-1:0] result_value,
    output logic             result_illegal,
    output logic [7:0]       result_tag
);

    iq_entry_t        in_entry;
    logic             in_pending;
    logic [7:0]       next_tag;
    logic             accept;
    iq_entry_t        q_entry;
    logic             q_valid;
    logic             q_read;
    logic             q_full;
    logic [4:0]       rf_raddr_a;
    logic [4:0]       rf_raddr_b;
    logic [`XLEN-1:0] rf_rdata_a;
    logic [`XLEN-1:0] rf_rdata_b;
    logic [4:0]       wb_busy_rd;

    issue_if issue_bus ();
    exec_if  exec_bus ();

    // Take a word once per req, only with room in the queue
    assign accept = instr_req && !instr_ack && !q_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_ack  <= 1'b0;
            in_pending <= 1'b0;
            next_tag   <= 8'd0;
        end else begin
            in_pending <= accept;
            if (accept) begin
                instr_ack <= 1'b1;
                next_tag  <= next_tag + 8'd1;
            end else if (instr_ack && !instr_req) begin
                instr_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            in_entry.word <= instr_word;
            in_entry.tag  <= next_tag;
        end
    end

    instr_queue instr_queue_i (
        .clk       (clk),
        .reset     (reset),
        .write     (in_pending),
        .read      (q_read),
        .data_in   (in_entry),
        .data_out  (q_entry),
        .valid_out (q_valid),
        .empty     (),
        .full      (q_full)
    );

    decode_unit decode_unit_i (
        .clk        (clk),
        .reset      (reset),
        .q_entry    (q_entry),
        .q_valid    (q_valid),
        .q_read     (q_read),
        .rf_raddr_a (rf_raddr_a),
        .rf_raddr_b (rf_raddr_b),
        .rf_rdata_a (rf_rdata_a),
        .rf_rdata_b (rf_rdata_b),
        .wb_busy_rd (wb_busy_rd),
        .issue      (issue_bus.decode)
    );

    alu_execute alu_execute_i (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue_bus.execute),
        .result (exec_bus.execute)
    );

    result_writeback result_writeback_i (
        .clk            (clk),
        .reset          (reset),
        .result         (exec_bus.writeback),
        .rf_raddr_a     (rf_raddr_a),
        .rf_raddr_b     (rf_raddr_b),
        .rf_rdata_a     (rf_rdata_a),
        .rf_rdata_b     (rf_rdata_b),
        .wb_busy_rd     (wb_busy_rd),
        .result_req     (result_req),
        .result_ack     (result_ack),
        .result_rd      (result_rd),
        .result_value   (result_value),
        .result_illegal (result_illegal),
        .result_tag     (result_tag)
    );

endmodule

// ==== tb/core_checker.sv ====
// ####################
// Core checker: reference model, port protocol checks and reporting
// ####################

`include "core_consts.svh"

module core_checker #(
    parameter int NUM_WORDS = 300
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_req,
    input  logic [`XLEN-1:0] instr_word,
    input  logic             instr_ack,
    input  logic             result_req,
    input  logic             result_ack,
    input  logic [4:0]       result_rd,
    input  logic [`XLEN-1:0] result_value,
    input  logic             result_illegal,
    input  logic [7:0]       result_tag,
    input  logic             report_now,
    output logic             report_done,
    output int               completed,
    output int               error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`XLEN-1:0] model_regs [`NUM_REGS];
    logic [`XLEN-1:0] word_q [$];
    logic [7:0]       expected_tag;
    logic [4:0]       held_rd;
    logic [`XLEN-1:0] held_value;
    logic             held_illegal;
    logic [7:0]       held_tag;
    logic             prev_reset;
    logic             prev_instr_ack;
    logic             prev_result_req;
    logic             prev_result_ack;
    int               accepted;
    int               wait_run;
    int               withheld;
    int               n_legal;
    int               n_illegal;
    int               n_x0;
    int               err_value;
    int               err_tag;
    int               err_illegal;
    int               err_x0;
    int               err_proto;
    int               err_reset;

    assign error_count = err_value + err_tag + err_illegal + err_x0 + err_proto + err_reset;

    // Architectural result of one word, from the RV32I subset rules
    task automatic compute_expected(input logic [`XLEN-1:0] w, output logic ill,
                                    output logic [4:0] rd, output logic [`XLEN-1:0] val);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{(`XLEN - 12){w[31]}}, w[31:20]};
        ill = 1'b0;
        val = '0;
        if (w[6:0] == 7'b0110011) begin
            case ({w[31:25], w[14:12]})
                10'b0000000_000: val = a + b;
                10'b0100000_000: val = a - b;
                10'b0000000_111: val = a & b;
                10'b0000000_110: val = a | b;
                10'b0000000_100: val = a ^ b;
                10'b0000000_010: val = ($signed(a) < $signed(b)) ? `XLEN'd1 : '0;
                default:         ill = 1'b1;
            endcase
        end else if (w[6:0] == 7'b0010011) begin
            case (w[14:12])
                3'b000:  val = a + imm;
                3'b111:  val = a & imm;
                3'b110:  val = a | imm;
                3'b100:  val = a ^ imm;
                3'b010:  val = ($signed(a) < $signed(imm)) ? `XLEN'd1 : '0;
                default: ill = 1'b1;
            endcase
        end else begin
            ill = 1'b1;
        end
        rd = ill ? 5'd0 : w[11:7];
        if (ill) begin
            val = '0;
        end
    endtask

    task automatic check_result();
        logic [`XLEN-1:0] w;
        logic             exp_ill;
        logic [4:0]       exp_rd;
        logic [`XLEN-1:0] exp_val;
        if (word_q.size() == 0) begin
            $display("Result with tag %0d arrived with no accepted word waiting", result_tag);
            err_tag++;
        end else begin
            w = word_q.pop_front();
            compute_expected(w, exp_ill, exp_rd, exp_val);
            if (result_tag != expected_tag) begin
                $display("Mismatch at %0d ns: tag %0d, expected %0d", $time,
                         result_tag, expected_tag);
                err_tag++;
            end
            if (result_illegal != exp_ill || result_rd != exp_rd || result_value != exp_val) begin
                $display("Mismatch at %0d ns: word %h gave rd %0d value %h illegal %b,",
                         " expected rd %0d value %h illegal %b",
                         $time, w, result_rd, result_value, result_illegal,
                         exp_rd, exp_val, exp_ill);
                if (exp_ill) begin
                    err_illegal++;
                end else if (w[11:7] == 5'd0) begin
                    err_x0++;
                end else begin
                    err_value++;
                end
            end
            if (exp_ill) begin
                n_illegal++;
            end else begin
                n_legal++;
                if (exp_rd == 5'd0) begin
                    n_x0++;
                end else begin
                    model_regs[exp_rd] = exp_val;
                end
            end
            expected_tag++;
            completed++;
        end
    endtask

    task automatic print_report();
        if (accepted != NUM_WORDS || completed != accepted || word_q.size() != 0) begin
            $display("Accepted %0d words and completed %0d results, expected %0d of each",
                     accepted, completed, NUM_WORDS);
            err_tag++;
        end
        if (n_illegal == 0) begin
            $display("No illegal word was seen in the traffic");
            err_illegal++;
        end
        if (n_x0 == 0) begin
            $display("No write to x0 was seen in the traffic");
            err_x0++;
        end
        if (withheld == 0) begin
            $display("instr_ack was never withheld, so back-pressure was not exercised");
            err_proto++;
        end
        $display("Test values and rd: %0d legal results, %0d errors", n_legal, err_value);
        $display("Test tag order: %0d results, %0d errors", completed, err_tag);
        $display("Test illegal words: %0d seen, %0d errors", n_illegal, err_illegal);
        $display("Test x0 writes: %0d seen, %0d errors", n_x0, err_x0);
        $display("Test handshake protocol: ack withheld %0d times, %0d errors",
                 withheld, err_proto);
        $display("Summary: %0d results checked, %0d errors", completed, error_count);
    endtask

    // Sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            word_q.delete();
            expected_tag = 8'd0;
            accepted     = 0;
            completed    = 0;
            wait_run     = 0;
            withheld     = 0;
            n_legal      = 0;
            n_illegal    = 0;
            n_x0         = 0;
            err_value    = 0;
            err_tag      = 0;
            err_illegal  = 0;
            err_x0       = 0;
            err_proto    = 0;
            err_reset    = 0;
            report_done  = 1'b0;
        end else begin
            if (prev_reset) begin
                if (instr_ack !== 1'b0 || result_req !== 1'b0) begin
                    $display("instr_ack or result_req was not low right after reset");
                    err_reset++;
                end
                $display("Test reset state: %0d errors", err_reset);
            end
            if (instr_ack && !prev_instr_ack) begin
                if (!instr_req) begin
                    $display("instr_ack rose at %0d ns while instr_req was low", $time);
                    err_proto++;
                end
                word_q.push_back(instr_word);
                accepted++;
            end
            // A word waiting more than one sample means the ack was held back
            wait_run = (instr_req && !instr_ack) ? wait_run + 1 : 0;
            if (wait_run == 2) begin
                withheld++;
            end
            if (result_req && !prev_result_req) begin
                if (result_ack || prev_result_ack) begin
                    $display("result_req rose at %0d ns while result_ack was high", $time);
                    err_proto++;
                end
                held_rd      = result_rd;
                held_value   = result_value;
                held_illegal = result_illegal;
                held_tag     = result_tag;
                check_result();
            end else if (result_req && prev_result_req) begin
                if ({result_rd, result_value, result_illegal, result_tag} !=
                    {held_rd, held_value, held_illegal, held_tag}) begin
                    $display("Result data changed at %0d ns while result_req was high", $time);
                    err_proto++;
                end
            end
            if (report_now && !report_done) begin
                print_report();
                report_done = 1'b1;
            end
        end
        prev_reset      = reset;
        prev_instr_ack  = instr_ack;
        prev_result_req = result_req;
        prev_result_ack = result_ack;
    end

endmodule

// ==== tb/mini_core_tb.sv ====
// ####################
// Testbench for the core slice with seeded random instruction traffic
// ####################

`include "core_consts.svh"

module mini_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_WORDS = 300;
    localparam int unsigned SEED      = 32'h43fc2f25;

    logic             clk;
    logic             reset;
    logic             instr_req;
    logic [`XLEN-1:0] instr_word;
    logic             instr_ack;
    logic             result_req;
    logic             result_ack;
    logic [4:0]       result_rd;
    logic [`XLEN-1:0] result_value;
    logic             result_illegal;
    logic [7:0]       result_tag;
    logic             report_now;
    logic             report_done;
    int               completed;
    int               error_count;

    always #10 clk = ~clk;

    mini_core_top mini_core_top_i (
        .clk            (clk),
        .reset          (reset),
        .instr_req      (instr_req),
        .instr_word     (instr_word),
        .instr_ack      (instr_ack),
        .result_req     (result_req),
        .result_ack     (result_ack),
        .result_rd      (result_rd),
        .result_value   (result_value),
        .result_illegal (result_illegal),
        .result_tag     (result_tag)
    );

    core_checker #(.NUM_WORDS(NUM_WORDS)) core_checker_i (
        .clk            (clk),
        .reset          (reset),
        .instr_req      (instr_req),
        .instr_word     (instr_word),
        .instr_ack      (instr_ack),
        .result_req     (result_req),
        .result_ack     (result_ack),
        .result_rd      (result_rd),
        .result_value   (result_value),
        .result_illegal (result_illegal),
        .result_tag     (result_tag),
        .report_now     (report_now),
        .report_done    (report_done),
        .completed      (completed),
        .error_count    (error_count)
    );

    // Small register range so hazards and x0 targets come up often
    function automatic logic [`XLEN-1:0] random_word();
        logic [`XLEN-1:0] w;
        int unsigned      kind;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [2:0]       f3;
        logic [6:0]       f7;
        kind = $urandom_range(99);
        rd   = 5'($urandom_range(15));
        rs1  = 5'($urandom_range(15));
        rs2  = 5'($urandom_range(15));
        f7   = 7'b0000000;
        if (kind < 5) begin
            w = $urandom();
            // Steer away from the two legal opcodes
            if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) begin
                w[2] = ~w[2];
            end
        end else if (kind < 52) begin
            case ($urandom_range(5))
                0: f3 = 3'b000;
                1: begin
                    f3 = 3'b000;
                    f7 = 7'b0100000;
                end
                2: f3 = 3'b111;
                3: f3 = 3'b110;
                4: f3 = 3'b100;
                default: f3 = 3'b010;
            endcase
            w = {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else begin
            case ($urandom_range(4))
                0: f3 = 3'b000;
                1: f3 = 3'b111;
                2: f3 = 3'b110;
                3: f3 = 3'b100;
                default: f3 = 3'b010;
            endcase
            w = {12'($urandom()), rs1, f3, rd, 7'b0010011};
        end
        return w;
    endfunction

    task automatic send_word(input logic [`XLEN-1:0] word);
        @(posedge clk);
        instr_req  <= 1'b1;
        instr_word <= word;
        @(negedge clk);
        while (!instr_ack) @(negedge clk);
        @(posedge clk);
        instr_req <= 1'b0;
        @(negedge clk);
        while (instr_ack) @(negedge clk);
    endtask

    task automatic produce_words();
        for (int i = 0; i < NUM_WORDS; i++) begin
            send_word(random_word());
        end
    endtask

    // Consumer side, ack after 0 to 6 idle clocks
    task automatic drive_result_ack();
        int unsigned delay;
        forever begin
            @(negedge clk);
            while (!result_req) @(negedge clk);
            delay = $urandom_range(6);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            result_ack <= 1'b1;
            @(negedge clk);
            while (result_req) @(negedge clk);
            @(posedge clk);
            result_ack <= 1'b0;
        end
    endtask

    initial begin : main
        int unsigned seed_val;
        seed_val   = $urandom(SEED);
        reset      = 1'b1;
        clk        = 1'b0;
        instr_req  = 1'b0;
        instr_word = '0;
        result_ack = 1'b0;
        report_now = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        fork
            produce_words();
            drive_result_ack();
        join_none
        @(negedge clk);
        while (completed < NUM_WORDS) @(negedge clk);
        // A few idle clocks to catch any extra result
        repeat (5) @(negedge clk);
        @(posedge clk);
        report_now <= 1'b1;
        @(negedge clk);
        while (!report_done) @(negedge clk);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_WORDS * 40) @(posedge clk);
        $display("Timeout: only %0d of %0d results completed in time", completed, NUM_WORDS);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/instr_queue.sv
hdl/decode_unit.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/mini_core_top.sv
tb/core_checker.sv
tb/mini_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := mini_core_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
